//--- logic/fis_rx_pkg.sv
// register map, fis lengths and shared types of the FIS receive path
// every receiver module and the testbench import this package
`default_nettype none

package fis_rx_pkg;

    localparam int reg_addr_bits = 10;                            // register word address width

    localparam logic [reg_addr_bits-1:0] fb_offs32    = 10'h300; // received-fis area base
    localparam logic [reg_addr_bits-1:0] pxtfd_offs32 = 10'h048; // PxTFD, err in 15:8, sts in 7:0
    localparam logic [reg_addr_bits-1:0] pxsig_offs32 = 10'h049; // PxSIG device signature

    localparam logic [reg_addr_bits-1:0] rfis_offs32   = 10'h010; // d2h register fis slot
    localparam logic [reg_addr_bits-1:0] sdbfis_offs32 = 10'h016; // set device bits slot
    localparam logic [reg_addr_bits-1:0] psfis_offs32  = 10'h008; // pio setup slot
    localparam logic [reg_addr_bits-1:0] ufis_offs32   = 10'h018; // unknown fis slot

    localparam logic [3:0] rfis_lenm1   = 4'd4;                   // fis lengths in dwords, minus one
    localparam logic [3:0] sdbfis_lenm1 = 4'd1;
    localparam logic [3:0] psfis_lenm1  = 4'd4;
    localparam logic [3:0] ufis_lenm1   = 4'd15;
    localparam logic [3:0] ignore_lenm1 = 4'd15;                  // nothing stored, length only limits

    typedef enum logic [1:0] {
        kind_data  = 2'd0,                                        // payload dword
        kind_head  = 2'd1,                                        // first dword, fis type in low byte
        kind_r_ok  = 2'd2,                                        // end of fis, crc good
        kind_r_err = 2'd3                                         // end of fis, crc bad
    } dword_kind_e;

    typedef enum logic [2:0] {
        fis_rfis,                                                 // d2h register
        fis_sdb,                                                  // set device bits
        fis_psfis,                                                // pio setup
        fis_ufis,                                                 // unknown, stored raw
        fis_ignore                                                // drained and dropped
    } fis_kind_e;

    typedef struct packed {
        fis_kind_e                kind;
        logic [reg_addr_bits-1:0] base_addr;                      // first storage word
        logic [3:0]               len_m1;
        logic                     save;                           // write words to register space
    } fis_job_t;

    typedef struct packed {
        logic [31:0] data;
        dword_kind_e kind;
    } stream_word_t;

    typedef struct packed {
        logic        valid;
        fis_kind_e   kind;
        logic [3:0]  index;                                       // dword position within the fis
        logic [31:0] data;
    } fis_word_t;

    typedef struct packed {
        logic                     we;
        logic [reg_addr_bits-1:0] addr;
        logic [31:0]              data;
    } reg_wr_t;

endpackage

`default_nettype wire

//--- logic/fis_job_decode.sv
// turns the get strobe and its fis kind into a registered receive job
// the job holds storage base, length and the save decision for the sequencer
`timescale 1ns/1ps
`default_nettype none

module fis_job_decode import fis_rx_pkg::*; (
    input  logic      mclk,
    input  logic      hba_rst,
    input  logic      get_fis,                 // start receiving one fis
    input  fis_kind_e get_kind,                // kind decoded from the header outside
    input  logic      pcmd_fre,                // fis receive enable
    input  logic      sig_pending,             // signature capture armed
    output fis_job_t  job,
    output logic      job_start                // one cycle after get_fis
);

    logic [reg_addr_bits-1:0] lut_offs;        // slot offset inside fis area
    logic [3:0]               lut_lenm1;
    logic                     lut_save;

    always_comb begin
        lut_offs  = ufis_offs32;
        lut_lenm1 = ignore_lenm1;
        lut_save  = 1'b0;                      // ignore never stores
        case (get_kind)
            fis_rfis: begin
                lut_offs  = rfis_offs32;
                lut_lenm1 = rfis_lenm1;
                lut_save  = sig_pending || pcmd_fre; // signature fis stored even with fre off
            end
            fis_sdb: begin
                lut_offs  = sdbfis_offs32;
                lut_lenm1 = sdbfis_lenm1;
                lut_save  = pcmd_fre;
            end
            fis_psfis: begin
                lut_offs  = psfis_offs32;
                lut_lenm1 = psfis_lenm1;
                lut_save  = pcmd_fre;
            end
            fis_ufis: begin
                lut_lenm1 = ufis_lenm1;
                lut_save  = pcmd_fre;
            end
            default: lut_lenm1 = ignore_lenm1;
        endcase
    end

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            job_start <= 1'b0;
        end else begin
            job_start <= get_fis;
        end
        if (get_fis) begin                     // job held until the next get
            job.kind      <= get_kind;
            job.base_addr <= fb_offs32 + lut_offs;
            job.len_m1    <= lut_lenm1;
            job.save      <= lut_save;
        end
    end

endmodule

`default_nettype wire

//--- logic/fis_word_sequencer.sv
// consumes stream dwords of the current job, numbers them and issues storage writes
// also keeps busy/done, completion flags and the idle header flag
`timescale 1ns/1ps
`default_nettype none

module fis_word_sequencer import fis_rx_pkg::*; (
    input  logic         mclk,
    input  logic         hba_rst,
    input  logic         get_fis,
    input  logic         job_start,
    input  fis_job_t     job,
    input  stream_word_t in_word,
    input  logic         in_valid,
    output logic         in_ready,             // combinational, high while a job runs
    output logic         fis_first_vld,        // header waiting while idle
    output logic         get_fis_busy,
    output logic         get_fis_done,         // one cycle pulse
    output logic         fis_ok,
    output logic         fis_err,
    output logic         fis_ferr,             // fis too long, sticky till reset
    output fis_word_t    rx_word,
    output reg_wr_t      store_wr
);

    logic       run;                           // job active, stream accepted
    logic [3:0] idx;                           // number of the next dword
    logic       len_done;                      // all stored-length dwords taken
    logic       take;                          // dword consumed this cycle
    logic       is_end;                        // r_ok or r_err marker
    logic       numbered;                      // consumed dword inside fis length

    assign in_ready = run;
    assign take     = in_valid && run;
    assign is_end   = (in_word.kind == kind_r_ok) || (in_word.kind == kind_r_err);
    assign numbered = take && !is_end && !len_done;

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            run      <= 1'b0;
            idx      <= '0;
            len_done <= 1'b0;
        end else if (job_start) begin
            run      <= 1'b1;
            idx      <= '0;
            len_done <= 1'b0;
        end else begin
            if (take && is_end) begin
                run <= 1'b0;
            end
            if (numbered) begin
                if (idx == job.len_m1) begin
                    len_done <= 1'b1;          // further dwords are surplus
                end else begin
                    idx <= idx + 4'd1;
                end
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            get_fis_busy  <= 1'b0;
            get_fis_done  <= 1'b0;
            fis_ok        <= 1'b0;
            fis_err       <= 1'b0;
            fis_ferr      <= 1'b0;
            fis_first_vld <= 1'b0;
        end else begin
            get_fis_done <= take && is_end;
            if (get_fis) begin
                get_fis_busy <= 1'b1;
                fis_ok       <= 1'b0;
                fis_err      <= 1'b0;
            end else if (take && is_end) begin
                get_fis_busy <= 1'b0;          // falls together with done
                fis_ok       <= (in_word.kind == kind_r_ok);
                fis_err      <= (in_word.kind == kind_r_err);
            end
            if (take && !is_end && len_done && (job.kind != fis_ignore)) begin
                fis_ferr <= 1'b1;
            end
            if (get_fis) begin
                fis_first_vld <= 1'b0;
            end else if (in_valid && (in_word.kind == kind_head) && !get_fis_busy) begin
                fis_first_vld <= 1'b1;
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            rx_word.valid <= 1'b0;
            store_wr.we   <= 1'b0;
        end else begin
            rx_word.valid <= numbered;         // tagged even when not saved
            store_wr.we   <= numbered && job.save;
        end
        rx_word.kind  <= job.kind;
        rx_word.index <= idx;
        rx_word.data  <= in_word.data;
        store_wr.addr <= job.base_addr + reg_addr_bits'(idx);
        store_wr.data <= in_word.data;
    end

endmodule

`default_nettype wire

//--- logic/taskfile_update.sv
// keeps PxTFD status/error, device signature and received fis fields
// merges storage and command writes onto the single register write port
`timescale 1ns/1ps
`default_nettype none

module taskfile_update import fis_rx_pkg::*; (
    input  logic       mclk,
    input  logic       hba_rst,
    input  fis_word_t  rx_word,                // tagged dword from the sequencer
    input  reg_wr_t    store_wr,               // fis storage write
    input  logic       update_err_sts,         // write PxTFD
    input  logic       update_sig,             // write PxSIG if pending
    input  logic       set_update_sig,         // re-arm signature capture
    input  logic       clear_bsy_drq,
    input  logic       set_bsy,
    output reg_wr_t    reg_wr,
    output logic [7:0] tfd_sts,                // bit 7 BSY, bit 3 DRQ
    output logic [7:0] tfd_err,
    output logic [7:0] pio_es,                 // pio setup E_Status
    output logic       sig_pending,
    output logic       sig_available,
    output logic       fis_i,
    output logic       sdb_n,
    output logic       pio_i,
    output logic       pio_d
);

    logic        rfis_w0;                      // d2h header dword
    logic        sdb_w0;
    logic        ps_w0;
    logic        ps_w3;                        // carries E_Status
    logic        sig_w1;                       // lba low dword of signature fis
    logic        sig_w3;                       // sector count dword
    logic        wr_tfd_r;                     // command write, first stage
    logic        wr_sig_r;
    logic [31:0] sig_r;

    assign rfis_w0 = rx_word.valid && (rx_word.kind == fis_rfis) && (rx_word.index == 4'd0);
    assign sdb_w0  = rx_word.valid && (rx_word.kind == fis_sdb) && (rx_word.index == 4'd0);
    assign ps_w0   = rx_word.valid && (rx_word.kind == fis_psfis) && (rx_word.index == 4'd0);
    assign ps_w3   = rx_word.valid && (rx_word.kind == fis_psfis) && (rx_word.index == 4'd3);
    assign sig_w1  = rx_word.valid && (rx_word.kind == fis_rfis) && (rx_word.index == 4'd1) &&
                     sig_pending;
    assign sig_w3  = rx_word.valid && (rx_word.kind == fis_rfis) && (rx_word.index == 4'd3) &&
                     sig_pending;

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            tfd_sts <= '0;
            tfd_err <= '0;
        end else if (rfis_w0 || ps_w0) begin
            tfd_sts <= rx_word.data[23:16];
            tfd_err <= rx_word.data[31:24];
        end else if (sdb_w0) begin             // sdb keeps BSY and DRQ
            tfd_sts <= {tfd_sts[7], rx_word.data[22:20], tfd_sts[3], rx_word.data[18:16]};
            tfd_err <= rx_word.data[31:24];
        end else if (clear_bsy_drq) begin
            tfd_sts <= tfd_sts & 8'h77;
        end else if (set_bsy) begin
            tfd_sts <= tfd_sts | 8'h80;
        end
    end

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            fis_i  <= 1'b0;
            sdb_n  <= 1'b0;
            pio_i  <= 1'b0;
            pio_d  <= 1'b0;
            pio_es <= '0;
        end else begin
            if (rfis_w0 || sdb_w0) begin
                fis_i <= rx_word.data[14];
            end
            if (sdb_w0) begin
                sdb_n <= rx_word.data[15];     // notification
            end
            if (ps_w0) begin
                pio_i <= rx_word.data[14];
                pio_d <= rx_word.data[13];     // transfer direction
            end
            if (ps_w3) begin
                pio_es <= rx_word.data[31:24];
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            sig_pending   <= 1'b1;             // first d2h after reset is the signature
            sig_available <= 1'b0;
            wr_tfd_r      <= 1'b0;
            wr_sig_r      <= 1'b0;
        end else begin
            if (set_update_sig) begin
                sig_pending <= 1'b1;
            end else if (update_sig) begin
                sig_pending <= 1'b0;
            end
            if (update_sig) begin
                sig_available <= 1'b0;
            end else if (sig_w3) begin
                sig_available <= 1'b1;
            end
            wr_tfd_r <= update_err_sts || clear_bsy_drq || set_bsy;
            wr_sig_r <= update_sig && sig_pending;   // second update_sig writes nothing
        end
        if (sig_w1) begin
            sig_r[31:8] <= rx_word.data[23:0];
        end
        if (sig_w3) begin
            sig_r[7:0] <= rx_word.data[7:0];
        end
    end

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            reg_wr.we <= 1'b0;
        end else begin
            reg_wr.we <= store_wr.we || wr_tfd_r || wr_sig_r;
        end
        if (store_wr.we) begin                 // storage has priority
            reg_wr.addr <= store_wr.addr;
            reg_wr.data <= store_wr.data;
        end else if (wr_tfd_r) begin
            reg_wr.addr <= pxtfd_offs32;
            reg_wr.data <= {16'h0000, tfd_err, tfd_sts};
        end else begin
            reg_wr.addr <= pxsig_offs32;
            reg_wr.data <= sig_r;
        end
    end

endmodule

`default_nettype wire

//--- logic/fis_rx_top.sv
// FIS receive block of the host port, stream in and register writes out
// get_fis with its kind starts one fis, get_fis_done marks its end
`timescale 1ns/1ps
`default_nettype none

module fis_rx_top import fis_rx_pkg::*; (
    input  logic         mclk,
    input  logic         hba_rst,
    input  logic         get_fis,
    input  fis_kind_e    get_kind,
    input  stream_word_t in_word,              // transport layer dword
    input  logic         in_valid,
    output logic         in_ready,
    input  logic         pcmd_fre,
    input  logic         update_err_sts,
    input  logic         update_sig,
    input  logic         set_update_sig,
    input  logic         clear_bsy_drq,
    input  logic         set_bsy,
    output logic         fis_first_vld,
    output logic         get_fis_busy,
    output logic         get_fis_done,
    output logic         fis_ok,
    output logic         fis_err,
    output logic         fis_ferr,
    output reg_wr_t      reg_wr,               // one-word register write port
    output logic [7:0]   tfd_sts,
    output logic [7:0]   tfd_err,
    output logic [7:0]   pio_es,
    output logic         sig_pending,
    output logic         sig_available,
    output logic         fis_i,
    output logic         sdb_n,
    output logic         pio_i,
    output logic         pio_d
);

    fis_job_t  job;                            // decode to sequencer
    logic      job_start;
    fis_word_t rx_word;                        // sequencer to task file
    reg_wr_t   store_wr;

    fis_job_decode u_decode (
        .mclk        (mclk),
        .hba_rst     (hba_rst),
        .get_fis     (get_fis),
        .get_kind    (get_kind),
        .pcmd_fre    (pcmd_fre),
        .sig_pending (sig_pending),
        .job         (job),
        .job_start   (job_start)
    );

    fis_word_sequencer u_seq (
        .mclk          (mclk),
        .hba_rst       (hba_rst),
        .get_fis       (get_fis),
        .job_start     (job_start),
        .job           (job),
        .in_word       (in_word),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .fis_first_vld (fis_first_vld),
        .get_fis_busy  (get_fis_busy),
        .get_fis_done  (get_fis_done),
        .fis_ok        (fis_ok),
        .fis_err       (fis_err),
        .fis_ferr      (fis_ferr),
        .rx_word       (rx_word),
        .store_wr      (store_wr)
    );

    taskfile_update u_tf (
        .mclk           (mclk),
        .hba_rst        (hba_rst),
        .rx_word        (rx_word),
        .store_wr       (store_wr),
        .update_err_sts (update_err_sts),
        .update_sig     (update_sig),
        .set_update_sig (set_update_sig),
        .clear_bsy_drq  (clear_bsy_drq),
        .set_bsy        (set_bsy),
        .reg_wr         (reg_wr),
        .tfd_sts        (tfd_sts),
        .tfd_err        (tfd_err),
        .pio_es         (pio_es),
        .sig_pending    (sig_pending),
        .sig_available  (sig_available),
        .fis_i          (fis_i),
        .sdb_n          (sdb_n),
        .pio_i          (pio_i),
        .pio_d          (pio_d)
    );

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
// clock and reset source for the fis receive testbench
// 4 ns mclk, reset held 5 cycles at start and again on rst_req
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    input  logic rst_req,                      // re-run the reset sequence
    output logic mclk,
    output logic hba_rst
);

    int rst_cnt;

    initial begin
        mclk = 1'b0;
        forever #2 mclk = ~mclk;
    end

    initial begin
        hba_rst = 1'b1;
        rst_cnt = 0;
    end

    always @(posedge mclk) begin
        if (rst_req) begin
            hba_rst <= 1'b1;
            rst_cnt <= 0;
        end else if (hba_rst) begin
            if (rst_cnt == 4) hba_rst <= 1'b0;     // released after 5 edges
            rst_cnt <= rst_cnt + 1;
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_fis_rx.sv
// testbench for the fis receive block, random fis words from an lcg
// expected register writes are queued and compared in order as reg_wr.we fires
`timescale 1ns/1ps
`default_nettype none

module tb_fis_rx import fis_rx_pkg::*; ();

    logic mclk, hba_rst, rst_req;
    logic get_fis, in_valid, in_ready, pcmd_fre;
    logic update_err_sts, update_sig, set_update_sig, clear_bsy_drq, set_bsy;
    logic fis_first_vld, get_fis_busy, get_fis_done, fis_ok, fis_err, fis_ferr;
    logic sig_pending, sig_available, fis_i, sdb_n, pio_i, pio_d;
    logic [7:0] tfd_sts, tfd_err, pio_es;
    fis_kind_e    get_kind;
    stream_word_t in_word;
    reg_wr_t      reg_wr;

    reg_wr_t     exp_q[$];                     // writes still to come, in order
    reg_wr_t     exp_e;
    logic [31:0] wd[0:19];                     // words of the next fis
    logic [31:0] lcg_state = 32'hf7de;
    logic [7:0]  exp_sts, exp_err, exp_es;
    logic [31:0] exp_sig;
    logic        exp_pend, exp_avail, exp_i, exp_n, exp_pio_i, exp_pio_d;
    int          err_cnt = 0;                  // wrong values
    int          other_cnt = 0;                // missing or unexpected writes
    int          n, t;

    tb_clock_gen u_clk (.rst_req(rst_req), .mclk(mclk), .hba_rst(hba_rst));

    fis_rx_top u_dut (.*);

    function automatic logic [31:0] lcg();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // expected {err, sts} after word 0 of a fis
    function automatic logic [15:0] ref_taskfile(fis_kind_e k, logic [31:0] w0, logic [7:0] sts);
        if (k == fis_sdb)
            return {w0[31:24], sts[7], w0[22:20], sts[3], w0[18:16]}; // BSY, DRQ kept
        return {w0[31:24], w0[23:16]};
    endfunction

    function automatic logic [9:0] ref_base(fis_kind_e k);
        case (k)
            fis_rfis:  return 10'h310;
            fis_sdb:   return 10'h316;
            fis_psfis: return 10'h308;
            default:   return 10'h318;
        endcase
    endfunction

    function automatic int ref_len(fis_kind_e k);
        return (k == fis_rfis || k == fis_psfis) ? 5 : (k == fis_sdb) ? 2 : 16;
    endfunction

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s is %h, expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $finish;
    endtask

    task automatic fill_words(input int cnt);
        for (int i = 0; i < cnt; i++) wd[i] = lcg();
    endtask

    // waits until every queued write has shown up
    task automatic drain_writes();
        for (int k = 0; k < 12; k++) begin
            @(posedge mclk);
            if (k >= 3 && exp_q.size() == 0) break;
        end
        if (exp_q.size() != 0) begin
            $display("%0d expected register writes never appeared", exp_q.size());
            other_cnt++;
            exp_q.delete();
        end
    endtask

    always @(posedge mclk) begin
        if (!hba_rst && reg_wr.we) begin
            if (exp_q.size() == 0) begin
                $display("register write to %h that was not expected", reg_wr.addr);
                other_cnt++;
            end else begin
                exp_e = exp_q.pop_front();
                if (reg_wr.addr !== exp_e.addr || reg_wr.data !== exp_e.data) begin
                    $display("[FAIL] %0t write %h:%h, expected %h:%h", $time,
                             reg_wr.addr, reg_wr.data, exp_e.addr, exp_e.data);
                    err_cnt++;
                end
            end
        end
    end

    task automatic send_fis(input fis_kind_e k, input int cnt, input dword_kind_e endk,
                            input logic fre);
        int          i;
        int          tmo;
        logic        save;
        logic [15:0] tf;
        logic [31:0] r;
        save = (k != fis_ignore) && (fre || (k == fis_rfis && exp_pend));
        for (i = 0; i < cnt && i < ref_len(k); i++)
            if (save) exp_q.push_back('{we: 1'b1, addr: ref_base(k) + 10'(i), data: wd[i]});
        @(posedge mclk);
        get_fis  <= 1'b1;
        get_kind <= k;
        pcmd_fre <= fre;
        in_valid <= 1'b0;
        @(posedge mclk);
        get_fis <= 1'b0;
        i = 0;
        tmo = 0;
        while (i <= cnt) begin
            @(posedge mclk);
            check_eq("get_fis_busy", get_fis_busy, 1); // high from one cycle after get_fis
            if (in_valid && in_ready) i++;    // presented word taken at this edge
            tmo++;
            if (tmo > 2000) abort_run("stream words were not consumed in time");
            r = lcg();
            if (i <= cnt) begin
                in_valid     <= (r[17:16] != 2'b00); // gap one time in four
                in_word.data <= (i < cnt) ? wd[i] : r;
                in_word.kind <= (i == 0) ? kind_head : (i < cnt) ? kind_data : endk;
            end else begin
                in_valid <= 1'b0;
            end
        end
        tmo = 0;
        while (!get_fis_done) begin
            @(posedge mclk);
            tmo++;
            if (tmo > 50) abort_run("get_fis_done never came after the end word");
        end
        check_eq("fis_ok", fis_ok, endk == kind_r_ok);
        check_eq("fis_err", fis_err, endk == kind_r_err);
        check_eq("get_fis_busy", get_fis_busy, 0);
        if (k == fis_rfis || k == fis_sdb || k == fis_psfis) begin
            tf = ref_taskfile(k, wd[0], exp_sts);
            {exp_err, exp_sts} = tf;
        end
        if (k != fis_ignore) begin
            if (k == fis_rfis || k == fis_sdb) exp_i = wd[0][14];
            if (k == fis_sdb) exp_n = wd[0][15];
            if (k == fis_psfis) {exp_pio_i, exp_pio_d} = wd[0][14:13];
            if (k == fis_psfis && cnt >= 4) exp_es = wd[3][31:24];
            if (k == fis_rfis && exp_pend && cnt >= 4) begin
                exp_sig   = {wd[1][23:0], wd[3][7:0]};
                exp_avail = 1'b1;
            end
        end
        @(posedge mclk);
        check_eq("tfd_sts", tfd_sts, exp_sts);
        check_eq("tfd_err", tfd_err, exp_err);
        check_eq("fis_i", fis_i, exp_i);
        check_eq("sdb_n", sdb_n, exp_n);
        check_eq("pio_i/pio_d", {pio_i, pio_d}, {exp_pio_i, exp_pio_d});
        check_eq("pio_es", pio_es, exp_es);
        check_eq("sig_available", sig_available, exp_avail);
        check_eq("sig_pending", sig_pending, exp_pend);
        drain_writes();
    endtask

    // 0 update_err_sts, 1 update_sig, 2 set_update_sig, 3 clear_bsy_drq, 4 set_bsy
    task automatic do_cmd(input int c);
        @(posedge mclk);
        case (c)
            0: update_err_sts <= 1'b1;
            1: begin
                update_sig <= 1'b1;
                if (exp_pend) exp_q.push_back('{we: 1'b1, addr: pxsig_offs32, data: exp_sig});
                exp_pend  = 1'b0;
                exp_avail = 1'b0;
            end
            2: begin
                set_update_sig <= 1'b1;
                exp_pend = 1'b1;
            end
            3: begin
                clear_bsy_drq <= 1'b1;
                exp_sts = exp_sts & 8'h77;
            end
            default: begin
                set_bsy <= 1'b1;
                exp_sts = exp_sts | 8'h80;
            end
        endcase
        if (c == 0 || c >= 3)
            exp_q.push_back('{we: 1'b1, addr: pxtfd_offs32, data: {16'h0, exp_err, exp_sts}});
        @(posedge mclk);
        {update_err_sts, update_sig, set_update_sig, clear_bsy_drq, set_bsy} <= 5'b0;
        drain_writes();
    endtask

    task automatic wait_reset_done();
        int tmo;
        tmo = 0;
        while (hba_rst !== 1'b0) begin
            @(posedge mclk);
            tmo++;
            if (tmo > 20) abort_run("reset was never released");
        end
        {exp_sts, exp_err, exp_es, exp_sig} = '0;
        {exp_avail, exp_i, exp_n, exp_pio_i, exp_pio_d} = '0;
        exp_pend = 1'b1;                       // signature armed by reset
    endtask

    initial begin
        {rst_req, get_fis, in_valid, pcmd_fre} = '0;
        {update_err_sts, update_sig, set_update_sig, clear_bsy_drq, set_bsy} = '0;
        get_kind = fis_ignore;
        in_word  = '0;
        wait_reset_done();
        fill_words(5);                         // signature fis, stored with fre low
        send_fis(fis_rfis, 5, kind_r_ok, 1'b0);
        do_cmd(1);
        do_cmd(1);                             // no second signature write
        do_cmd(2);
        fill_words(5);
        send_fis(fis_rfis, 5, kind_r_ok, 1'b1);
        fill_words(5);
        wd[0] = wd[0] | 32'h0008_0000;         // DRQ set by the d2h fis
        send_fis(fis_rfis, 5, kind_r_ok, 1'b1);
        do_cmd(4);
        fill_words(2);
        send_fis(fis_sdb, 2, kind_r_ok, 1'b1);
        check_eq("BSY and DRQ after sdb", {tfd_sts[7], tfd_sts[3]}, 2'b11);
        do_cmd(3);
        do_cmd(0);
        fill_words(5);
        send_fis(fis_psfis, 5, kind_r_ok, 1'b1);
        n = 1 + int'(lcg() % 16);
        fill_words(n);
        send_fis(fis_ignore, n, kind_r_ok, 1'b1);
        fill_words(18);                        // two words too many for unknown fis
        send_fis(fis_ufis, 18, kind_r_ok, 1'b1);
        check_eq("fis_ferr", fis_ferr, 1);
        fill_words(5);
        send_fis(fis_rfis, 5, kind_r_ok, 1'b1);
        check_eq("fis_ferr sticky", fis_ferr, 1);
        @(posedge mclk);
        in_valid <= 1'b1;                      // header waits while idle
        in_word  <= '{data: lcg(), kind: kind_head};
        t = 0;
        while (!fis_first_vld) begin
            @(posedge mclk);
            t++;
            if (t > 20) abort_run("fis_first_vld never rose for an idle header");
        end
        fill_words(5);
        send_fis(fis_rfis, 5, kind_r_err, 1'b1);
        check_eq("fis_first_vld", fis_first_vld, 0);
        do_cmd(1);                             // re-armed signature written, pending cleared
        @(posedge mclk);
        rst_req <= 1'b1;
        @(posedge mclk);
        rst_req <= 1'b0;
        @(posedge mclk);
        wait_reset_done();
        @(posedge mclk);
        check_eq("fis_ferr after reset", fis_ferr, 0);
        check_eq("sig_pending after reset", sig_pending, 1);
        check_eq("tfd_sts after reset", tfd_sts, 0);
        $display("errors: %0d wrong values, %0d other failures", err_cnt, other_cnt);
        if (err_cnt == 0 && other_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- fis_rx.f
logic/fis_rx_pkg.sv
logic/fis_job_decode.sv
logic/fis_word_sequencer.sv
logic/taskfile_update.sv
logic/fis_rx_top.sv
tb/tb_clock_gen.sv
tb/tb_fis_rx.sv

//--- run_sim.sh
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f fis_rx.f --top-module tb_fis_rx \
    --Mdir obj_dir -o tb_fis_rx &&
./obj_dir/tb_fis_rx | grep "TB PASSED" || { echo "simulation did not pass"; exit 1; }
